// ==== src/lawnPkg.sv ====
`default_nettype none

package lawnPkg;

	// screen coordinate, also used for zombie x positions
	typedef logic [9:0] coord_t;
	// 4 bits per channel, r g b
	typedef logic [11:0] color_t;
	typedef logic [2:0] hitCount_t;
	typedef logic [15:0] killCount_t;

	// level machine, later levels not kept
	typedef enum logic [1:0]
	{
		Playing,
		LevelClear,
		Lost
	} gameState_e;

	// order matches the seed bar boxes left to right
	typedef enum logic [1:0]
	{
		NoPlant,
		PeaShooter,
		Sunflower,
		Wallnut
	} plantType_e;

	// one zombie per lane
	localparam int LANES = 5;

	// palette
	localparam color_t BLACK = 12'h000;
	localparam color_t GREY = 12'h0B4;
	localparam color_t GREEN = 12'h0F0;
	localparam color_t DARK_GREEN = 12'h392;
	localparam color_t RED = 12'hF00;
	localparam color_t ZOMBIE_SKIN = 12'hAAB;

	// zombies enter at the right edge of the lawn
	localparam coord_t LAWN_START_X = 10'd799;
	// reaching this x loses the level
	localparam coord_t END_OF_LAWN = 10'd124;
	localparam coord_t SEED_BAR_BOTTOM = 10'd159;
	localparam coord_t LANE_TOP_0 = 10'd160;
	localparam coord_t LANE_HEIGHT = 10'd128;
	localparam coord_t BODY_HEIGHT = 10'd100;
	localparam coord_t BODY_HALF_WIDTH = 10'd8;
	// plant box and grid square share a width
	localparam coord_t BOX_WIDTH = 10'd160;
	localparam coord_t OUTLINE_WIDTH = 10'd5;
	// left edge of the rightmost plant box
	localparam coord_t CURSOR_MAX_X = 10'd320;
	// staggered entry thresholds
	localparam coord_t RELEASE_NEAR = 10'd600;
	localparam coord_t RELEASE_FAR = 10'd700;

	// fifth hit kills
	localparam hitCount_t KILL_HITS = 3'd5;

endpackage

`default_nettype wire

// ==== src/hordeIf.sv ====
`default_nettype none

interface hordeIf;
	import lawnPkg::*;

	// per-lane zombie x, lane i in element i
	coord_t [LANES-1:0] zombieX;
	logic [LANES-1:0] alive;
	// one cycle high on the kill edge
	logic [LANES-1:0] killPulse;
	// high only while the level runs
	logic playing;

	// zombie side, owns positions and kills
	modport horde (output zombieX, output alive, output killPulse, input playing);

	// level control, watches the horde
	modport control (input zombieX, input alive, input killPulse, output playing);

	// drawing only needs where and whether
	modport display (input zombieX, input alive);

endinterface

`default_nettype wire

// ==== src/zombieLane.sv ====
`default_nettype none

module zombieLane (
	input logic clk,
	input logic rstN,
	input logic step,
	input logic released,
	input logic hit,
	output lawnPkg::coord_t zombieX,
	output logic alive,
	output logic killPulse
);
	import lawnPkg::*;

	hitCount_t hits;
	hitCount_t hitsNext;

	assign hitsNext = hits + 3'd1;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			zombieX <= LAWN_START_X;
			hits <= '0;
			alive <= 1'b1;
			killPulse <= 1'b0;
		end
		else
		begin
			killPulse <= 1'b0;
			// dead zombies stay where they fell
			if (step && released && alive)
				zombieX <= zombieX - 10'd1;
			if (hit && alive)
			begin
				hits <= hitsNext;
				// last hit, drop out and tell the kill counter
				if (hitsNext == KILL_HITS)
				begin
					alive <= 1'b0;
					killPulse <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/zombieHorde.sv ====
`default_nettype none

module zombieHorde #(
	parameter int STEP_CYCLES = 500000
) (
	input logic clk,
	input logic rstN,
	input logic [lawnPkg::LANES-1:0] peaHit,
	hordeIf.horde horde
);
	import lawnPkg::*;

	// extra bit so a divide by one still gets a counter
	localparam int CNT_W = $clog2(STEP_CYCLES + 1);
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(STEP_CYCLES - 1);

	logic [CNT_W-1:0] stepCount;
	logic step;
	logic [LANES-1:0] laneRelease;
	logic [LANES-1:0] hitGated;

	// step divider, frozen once the level ends
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			stepCount <= '0;
		else if (horde.playing)
		begin
			if (stepCount == LAST_COUNT)
				stepCount <= '0;
			else
				stepCount <= stepCount + 1'b1;
		end
	end

	// step lands on the edge closing each interval
	assign step = horde.playing && (stepCount == LAST_COUNT);

	// staggered entry, lane 1 leads
	assign laneRelease[1] = 1'b1;
	assign laneRelease[0] = horde.zombieX[1] <= RELEASE_NEAR;
	assign laneRelease[2] = horde.zombieX[0] <= RELEASE_NEAR;
	// lanes 3 and 4 follow closer behind
	assign laneRelease[3] = horde.zombieX[0] <= RELEASE_FAR;
	assign laneRelease[4] = horde.zombieX[3] <= RELEASE_FAR;

	// no hits count after the level ends
	assign hitGated = peaHit & {LANES{horde.playing}};

	for (genvar i = 0; i < LANES; i++)
	begin : genLane
		zombieLane laneInst (
			.clk(clk),
			.rstN(rstN),
			.step(step),
			.released(laneRelease[i]),
			.hit(hitGated[i]),
			.zombieX(horde.zombieX[i]),
			.alive(horde.alive[i]),
			.killPulse(horde.killPulse[i])
		);
	end

endmodule

`default_nettype wire

// ==== src/gameControl.sv ====
`default_nettype none

module gameControl (
	input logic clk,
	input logic rstN,
	hordeIf.control control,
	output lawnPkg::killCount_t zombiesKilled,
	output lawnPkg::gameState_e gameState
);
	import lawnPkg::*;

	killCount_t killsNow;
	killCount_t killedNext;
	logic reachedEnd;

	// two lanes may die on the same edge
	always_comb
	begin
		killsNow = '0;
		for (int i = 0; i < LANES; i++)
			killsNow = killsNow + killCount_t'(control.killPulse[i]);
	end

	assign killedNext = zombiesKilled + killsNow;

	// only live zombies can break through
	always_comb
	begin
		reachedEnd = 1'b0;
		for (int i = 0; i < LANES; i++)
			if (control.alive[i] && (control.zombieX[i] == END_OF_LAWN))
				reachedEnd = 1'b1;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			zombiesKilled <= '0;
			gameState <= Playing;
		end
		else
		begin
			zombiesKilled <= killedNext;
			// win and loss both hold until reset
			case (gameState)
				Playing:
					if (killedNext == killCount_t'(LANES))
						gameState <= LevelClear;
					else if (reachedEnd)
						gameState <= Lost;
				default:
					gameState <= gameState;
			endcase
		end
	end

	assign control.playing = (gameState == Playing);

endmodule

`default_nettype wire

// ==== src/plantSelector.sv ====
`default_nettype none

module plantSelector (
	input logic clk,
	input logic rstN,
	input logic selectButton,
	input logic leftButton,
	input logic rightButton,
	output lawnPkg::coord_t cursorX,
	output logic selecting,
	output lawnPkg::plantType_e plantChoice
);
	import lawnPkg::*;

	// previous sample, select left right
	logic [2:0] buttonQ;
	logic selectPress;
	logic leftPress;
	logic rightPress;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			buttonQ <= '0;
		else
			buttonQ <= {selectButton, leftButton, rightButton};
	end

	// one press per rising edge, holding does nothing
	assign selectPress = selectButton && !buttonQ[2];
	assign leftPress = leftButton && !buttonQ[1];
	assign rightPress = rightButton && !buttonQ[0];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cursorX <= '0;
			selecting <= 1'b0;
			plantChoice <= NoPlant;
		end
		else if (!selecting)
		begin
			// idle, only select matters
			if (selectPress)
			begin
				selecting <= 1'b1;
				cursorX <= '0;
			end
		end
		else if (selectPress)
		begin
			// box under the cursor picks the plant
			case (cursorX)
				10'd0:
					plantChoice <= PeaShooter;
				BOX_WIDTH:
					plantChoice <= Sunflower;
				CURSOR_MAX_X:
					plantChoice <= Wallnut;
				default:
					plantChoice <= plantChoice;
			endcase
			selecting <= 1'b0;
			cursorX <= '0;
		end
		else if (leftPress)
		begin
			// clamp at the leftmost box
			if (cursorX >= BOX_WIDTH)
				cursorX <= cursorX - BOX_WIDTH;
		end
		else if (rightPress)
		begin
			if (cursorX < CURSOR_MAX_X)
				cursorX <= cursorX + BOX_WIDTH;
		end
	end

endmodule

`default_nettype wire

// ==== src/pixelPainter.sv ====
`default_nettype none

module pixelPainter (
	input logic bright,
	input lawnPkg::coord_t hCount,
	input lawnPkg::coord_t vCount,
	input lawnPkg::coord_t cursorX,
	input logic selecting,
	hordeIf.display display,
	output lawnPkg::color_t rgb
);
	import lawnPkg::*;

	// dark squares on every other band
	localparam int BANDS = 3;

	coord_t boxRight;
	logic inBox;
	logic onBorder;
	logic cursorOutline;
	logic [10:0] hWide;
	logic [LANES-1:0] onBody;
	logic rowBand;
	logic colBand;

	// cursor box spans the seed bar height
	assign boxRight = cursorX + BOX_WIDTH - 10'd1;
	assign inBox = (hCount >= cursorX) && (hCount <= boxRight)
		&& (vCount <= SEED_BAR_BOTTOM);
	assign onBorder = (hCount < cursorX + OUTLINE_WIDTH)
		|| (hCount > boxRight - OUTLINE_WIDTH)
		|| (vCount < OUTLINE_WIDTH)
		|| (vCount > SEED_BAR_BOTTOM - OUTLINE_WIDTH);
	assign cursorOutline = selecting && inBox && onBorder;

	// widened so x plus half width cannot wrap
	assign hWide = {1'b0, hCount};

	for (genvar i = 0; i < LANES; i++)
	begin : genBody
		localparam coord_t LANE_TOP = coord_t'(LANE_TOP_0 + i * LANE_HEIGHT);
		logic [10:0] xWide;
		logic inRows;
		logic inCols;

		assign xWide = {1'b0, display.zombieX[i]};
		assign inRows = (vCount >= LANE_TOP) && (vCount < LANE_TOP + BODY_HEIGHT);
		// body is x-8 to x+8
		assign inCols = (hWide + 11'(BODY_HALF_WIDTH) >= xWide)
			&& (hWide <= xWide + 11'(BODY_HALF_WIDTH));
		assign onBody[i] = display.alive[i] && inRows && inCols;
	end

	// lanes 0 2 4 crossed with grid columns 1 3 5
	always_comb
	begin
		rowBand = 1'b0;
		colBand = 1'b0;
		for (int k = 0; k < BANDS; k++)
		begin
			if ((vCount >= coord_t'(LANE_TOP_0 + 2 * k * LANE_HEIGHT))
				&& (vCount < coord_t'(LANE_TOP_0 + (2 * k + 1) * LANE_HEIGHT)))
				rowBand = 1'b1;
			if ((hCount >= coord_t'((2 * k + 1) * BOX_WIDTH))
				&& (hCount < coord_t'((2 * k + 2) * BOX_WIDTH)))
				colBand = 1'b1;
		end
	end

	// priority, blanking first, lawn last
	always_comb
	begin
		if (!bright)
			rgb = BLACK;
		else if (cursorOutline)
			rgb = RED;
		else if (|onBody)
			rgb = ZOMBIE_SKIN;
		else if (vCount <= SEED_BAR_BOTTOM)
			rgb = GREY;
		else if (rowBand && colBand)
			rgb = DARK_GREEN;
		else
			rgb = GREEN;
	end

endmodule

`default_nettype wire

// ==== src/lawnGameTop.sv ====
`default_nettype none

module lawnGameTop #(
	parameter int STEP_CYCLES = 500000
) (
	input logic clk,
	input logic rstN,
	// vga timing side
	input logic bright,
	input lawnPkg::coord_t hCount,
	input lawnPkg::coord_t vCount,
	// board buttons, raw levels
	input logic selectButton,
	input logic leftButton,
	input logic rightButton,
	// one bit per lane, each high cycle is one hit
	input logic [lawnPkg::LANES-1:0] peaHit,
	output lawnPkg::color_t rgb,
	output lawnPkg::killCount_t zombiesKilled,
	output lawnPkg::gameState_e gameState,
	output lawnPkg::plantType_e plantChoice
);

	lawnPkg::coord_t cursorX;
	logic selecting;

	// shared horde state
	hordeIf hordeBus ();

	zombieHorde #(
		.STEP_CYCLES(STEP_CYCLES)
	) hordeInst (
		.clk(clk),
		.rstN(rstN),
		.peaHit(peaHit),
		.horde(hordeBus.horde)
	);

	// level state and kill tally
	gameControl controlInst (
		.clk(clk),
		.rstN(rstN),
		.control(hordeBus.control),
		.zombiesKilled(zombiesKilled),
		.gameState(gameState)
	);

	// seed bar cursor
	plantSelector selectorInst (
		.clk(clk),
		.rstN(rstN),
		.selectButton(selectButton),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.cursorX(cursorX),
		.selecting(selecting),
		.plantChoice(plantChoice)
	);

	// colour per pixel, no pipeline
	pixelPainter painterInst (
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.cursorX(cursorX),
		.selecting(selecting),
		.display(hordeBus.display),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== bench/lawnGameChecks.svh ====
`ifndef LAWN_GAME_CHECKS_SVH
`define LAWN_GAME_CHECKS_SVH

// one compare per result kind, typed like the dut ports

// name carries the probed pixel
task automatic checkColor(string name, color_t expected, color_t actual);
	if (actual !== expected)
		stopWithFailure($sformatf("Mismatch at time %0t: %s expected %h, got %h",
			$time, name, expected, actual));
endtask

task automatic checkKills(killCount_t expected, killCount_t actual);
	if (actual !== expected)
		stopWithFailure($sformatf("Mismatch at time %0t: zombiesKilled expected %0d, got %0d",
			$time, expected, actual));
endtask

// enum names, raw code kept for illegal values
task automatic checkState(gameState_e expected, gameState_e actual);
	if (actual !== expected)
		stopWithFailure($sformatf("Mismatch at time %0t: gameState expected %s, got %s (%0d)",
			$time, expected.name(), actual.name(), actual));
endtask

task automatic checkPlant(plantType_e expected, plantType_e actual);
	if (actual !== expected)
		stopWithFailure($sformatf("Mismatch at time %0t: plantChoice expected %s, got %s (%0d)",
			$time, expected.name(), actual.name(), actual));
endtask

`endif

// ==== bench/lawnGameTb.sv ====
`default_nettype none

module lawnGameTb;
	timeunit 1ns;
	timeprecision 1ps;
	import lawnPkg::*;

	localparam int STEP_CYCLES = 4;
	localparam int HALF_PERIOD = 10;
	// twice the longest march plus slack for reset and setup
	localparam int WATCHDOG_NS = 2 * 700 * STEP_CYCLES * 2 * HALF_PERIOD + 20000;

	// geometry as plain ints for the model
	localparam int START_X = int'(LAWN_START_X);
	localparam int END_X = int'(END_OF_LAWN);
	localparam int BAR_BOTTOM = int'(SEED_BAR_BOTTOM);
	localparam int TOP_0 = int'(LANE_TOP_0);
	localparam int LANE_H = int'(LANE_HEIGHT);
	localparam int BODY_H = int'(BODY_HEIGHT);
	localparam int HALF_W = int'(BODY_HALF_WIDTH);
	localparam int BOX_W = int'(BOX_WIDTH);
	localparam int NEAR = int'(RELEASE_NEAR);
	localparam int FAR = int'(RELEASE_FAR);
	localparam int HITS_TO_KILL = int'(KILL_HITS);

	// table opcodes
	localparam int OP_PRESS = 0;
	localparam int OP_HIT = 1;
	localparam int OP_STEPS = 2;
	localparam int OP_PIXEL = 3;
	localparam int OP_BLANK = 4;
	localparam int OP_LANE = 5;
	localparam int OP_RANDPIX = 6;
	localparam int OP_KILLS = 7;
	localparam int OP_STATE = 8;
	localparam int OP_PLANT = 9;
	localparam int OP_WINHITS = 10;
	localparam int OP_RESET = 11;
	localparam int OP_LOSS = 12;
	localparam int BTN_SELECT = 0;
	localparam int BTN_LEFT = 1;
	localparam int BTN_RIGHT = 2;

	// one table row, fields used per opcode
	typedef struct packed
	{
		int op;
		int a;
		int b;
		int val;
	} entry_t;

	logic clk = 1'b0;
	logic rstN;
	logic bright;
	coord_t hCount;
	coord_t vCount;
	logic selectButton;
	logic leftButton;
	logic rightButton;
	logic [LANES-1:0] peaHit;
	color_t rgb;
	killCount_t zombiesKilled;
	gameState_e gameState;
	plantType_e plantChoice;

	// reference model state
	int cycleCount;
	int modelSteps;
	int modelX [LANES];
	int modelHits [LANES];
	bit modelAlive [LANES];
	bit modelPlaying;
	bit modelLost;
	bit freed [LANES];
	bit stepNow;
	bit anyAlive;

	entry_t opQueue[$];

	lawnGameTop #(
		.STEP_CYCLES(STEP_CYCLES)
	) dut_i (
		.clk(clk),
		.rstN(rstN),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.selectButton(selectButton),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.peaHit(peaHit),
		.rgb(rgb),
		.zombiesKilled(zombiesKilled),
		.gameState(gameState),
		.plantChoice(plantChoice)
	);

	always #HALF_PERIOD clk = ~clk;

	// position model, moves on the same edges as the dut
	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cycleCount = 0;
			modelSteps = 0;
			modelPlaying = 1'b1;
			modelLost = 1'b0;
			for (int i = 0; i < LANES; i++)
			begin
				modelX[i] = START_X;
				modelHits[i] = 0;
				modelAlive[i] = 1'b1;
			end
		end
		else
		begin
			cycleCount++;
			stepNow = (cycleCount % STEP_CYCLES) == 0;
			// interval count keeps going so waits never stall
			if (stepNow)
				modelSteps++;
			if (modelPlaying)
			begin
				// entry order judged on positions before the step
				freed[1] = 1'b1;
				freed[0] = modelX[1] <= NEAR;
				freed[2] = modelX[0] <= NEAR;
				freed[3] = modelX[0] <= FAR;
				freed[4] = modelX[3] <= FAR;
				for (int i = 0; i < LANES; i++)
				begin
					if (stepNow && freed[i] && modelAlive[i])
						modelX[i]--;
					if (peaHit[i] && modelAlive[i])
					begin
						modelHits[i]++;
						if (modelHits[i] == HITS_TO_KILL)
							modelAlive[i] = 1'b0;
					end
				end
				// all dead wins, a live one at the end loses
				anyAlive = 1'b0;
				for (int i = 0; i < LANES; i++)
				begin
					anyAlive |= modelAlive[i];
					if (modelAlive[i] && modelX[i] == END_X)
						modelLost = 1'b1;
				end
				if (!anyAlive || modelLost)
					modelPlaying = 1'b0;
			end
		end
	end

	task automatic stopWithFailure(string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	`include "lawnGameChecks.svh"

	// background only, seed bar then checkerboard
	function automatic color_t lawnColor(int h, int v);
		int rowBand;
		int colBand;
		if (v <= BAR_BOTTOM)
			return GREY;
		rowBand = (v - TOP_0) / LANE_H;
		colBand = h / BOX_W;
		// even lanes against odd grid columns
		if (rowBand <= 4 && rowBand % 2 == 0 && colBand <= 5 && colBand % 2 == 1)
			return DARK_GREEN;
		return GREEN;
	endfunction

	// cursor not included, only used while idle
	function automatic color_t expectColor(int h, int v);
		int top;
		for (int i = 0; i < LANES; i++)
		begin
			top = TOP_0 + i * LANE_H;
			if (modelAlive[i] && v >= top && v < top + BODY_H
				&& h + HALF_W >= modelX[i] && h <= modelX[i] + HALF_W)
				return ZOMBIE_SKIN;
		end
		return lawnColor(h, v);
	endfunction

	task automatic addOp(int op, int a, int b, int val);
		opQueue.push_back(entry_t'{op, a, b, val});
	endtask

	task automatic pressButton(int which);
		@(negedge clk);
		selectButton = (which == BTN_SELECT);
		leftButton = (which == BTN_LEFT);
		rightButton = (which == BTN_RIGHT);
		@(negedge clk);
		selectButton = 1'b0;
		leftButton = 1'b0;
		rightButton = 1'b0;
		// low cycle so the next press is a fresh edge
		@(negedge clk);
	endtask

	// each high cycle is one hit
	task automatic pulseHit(int lane, int count);
		repeat (count)
		begin
			@(negedge clk);
			peaHit[lane] = 1'b1;
			@(negedge clk);
			peaHit = '0;
		end
	endtask

	task automatic waitSteps(int n);
		int target;
		target = modelSteps + n;
		while (modelSteps < target)
			@(negedge clk);
		// probe mid interval
		repeat (2) @(negedge clk);
	endtask

	// called on a falling edge
	task automatic probePixel(int h, int v, logic lit, color_t expected);
		hCount = coord_t'(h);
		vCount = coord_t'(v);
		bright = lit;
		// rgb is combinational, settle away from the edges
		#(HALF_PERIOD / 2);
		checkColor($sformatf("rgb at (%0d,%0d)", h, v), expected, rgb);
	endtask

	// finish every live lane, lanes drawn in random order
	task automatic hitAllRandom();
		int hitsLeft [LANES];
		int total;
		int lane;
		total = 0;
		for (int i = 0; i < LANES; i++)
		begin
			hitsLeft[i] = modelAlive[i] ? HITS_TO_KILL - modelHits[i] : 0;
			total += hitsLeft[i];
		end
		while (total > 0)
		begin
			lane = int'($urandom_range(LANES - 1, 0));
			if (hitsLeft[lane] > 0)
			begin
				pulseHit(lane, 1);
				hitsLeft[lane]--;
				total--;
			end
		end
	endtask

	task automatic resetDut();
		@(negedge clk);
		rstN = 1'b0;
		repeat (3) @(negedge clk);
		rstN = 1'b1;
	endtask

	task automatic buildTable();
		// fresh screen
		addOp(OP_STATE, 0, 0, int'(Playing));
		addOp(OP_KILLS, 0, 0, 0);
		addOp(OP_PLANT, 0, 0, int'(NoPlant));
		addOp(OP_PIXEL, 0, 0, int'(GREY));
		addOp(OP_PIXEL, 639, 159, int'(GREY));
		addOp(OP_PIXEL, 200, 200, int'(DARK_GREEN));
		addOp(OP_PIXEL, 900, 700, int'(DARK_GREEN));
		addOp(OP_PIXEL, 100, 200, int'(GREEN));
		addOp(OP_PIXEL, 200, 300, int'(GREEN));
		addOp(OP_BLANK, 200, 200, 0);
		addOp(OP_BLANK, 5, 5, 0);
		addOp(OP_RANDPIX, 40, 0, 0);
		// cursor, third right press clamps at 320
		addOp(OP_PRESS, BTN_SELECT, 0, 0);
		addOp(OP_PRESS, BTN_RIGHT, 0, 0);
		addOp(OP_PRESS, BTN_RIGHT, 0, 0);
		addOp(OP_PRESS, BTN_RIGHT, 0, 0);
		addOp(OP_PIXEL, 320, 80, int'(RED));
		addOp(OP_PIXEL, 479, 80, int'(RED));
		addOp(OP_PIXEL, 400, 2, int'(RED));
		addOp(OP_PIXEL, 400, 80, int'(GREY));
		addOp(OP_PIXEL, 319, 80, int'(GREY));
		addOp(OP_PRESS, BTN_LEFT, 0, 0);
		addOp(OP_PRESS, BTN_SELECT, 0, 0);
		addOp(OP_PLANT, 0, 0, int'(Sunflower));
		addOp(OP_PIXEL, 160, 80, int'(GREY));
		addOp(OP_PRESS, BTN_LEFT, 0, 0);
		addOp(OP_PLANT, 0, 0, int'(Sunflower));
		addOp(OP_PIXEL, 0, 80, int'(GREY));
		// march, lanes 2 to 4 still waiting
		addOp(OP_STEPS, 210, 0, 0);
		for (int i = 0; i < LANES; i++)
			addOp(OP_LANE, i, 0, 0);
		addOp(OP_PIXEL, 807, 466, int'(ZOMBIE_SKIN));
		addOp(OP_PIXEL, 808, 466, int'(DARK_GREEN));
		// four hits leave lane 1 standing, the fifth kills
		addOp(OP_HIT, 1, 4, 0);
		addOp(OP_STEPS, 1, 0, 0);
		addOp(OP_LANE, 1, 0, 0);
		addOp(OP_KILLS, 0, 0, 0);
		addOp(OP_HIT, 1, 1, 0);
		addOp(OP_KILLS, 0, 0, 1);
		addOp(OP_LANE, 1, 0, 0);
		// win
		addOp(OP_WINHITS, 0, 0, 0);
		addOp(OP_KILLS, 0, 0, 5);
		addOp(OP_STATE, 0, 0, int'(LevelClear));
		addOp(OP_STEPS, 5, 0, 0);
		addOp(OP_STATE, 0, 0, int'(LevelClear));
		addOp(OP_RANDPIX, 20, 0, 0);
		// loss on a fresh level
		addOp(OP_RESET, 0, 0, 0);
		addOp(OP_STATE, 0, 0, int'(Playing));
		addOp(OP_KILLS, 0, 0, 0);
		addOp(OP_PLANT, 0, 0, int'(NoPlant));
		addOp(OP_LOSS, 0, 0, 0);
		addOp(OP_STEPS, 3, 0, 0);
		addOp(OP_PIXEL, 132, 338, int'(ZOMBIE_SKIN));
		addOp(OP_PIXEL, 116, 338, int'(ZOMBIE_SKIN));
		addOp(OP_LANE, 0, 0, 0);
		addOp(OP_LANE, 3, 0, 0);
		addOp(OP_STATE, 0, 0, int'(Lost));
	endtask

	task automatic applyOp(entry_t e);
		int h;
		int v;
		case (e.op)
			OP_PRESS:
				pressButton(e.a);
			OP_HIT:
				pulseHit(e.a, e.b);
			OP_STEPS:
				waitSteps(e.a);
			OP_PIXEL:
			begin
				@(negedge clk);
				probePixel(e.a, e.b, 1'b1, color_t'(e.val));
			end
			OP_BLANK:
			begin
				@(negedge clk);
				probePixel(e.a, e.b, 1'b0, BLACK);
			end
			OP_LANE:
			begin
				// body centre at the model position
				@(negedge clk);
				h = modelX[e.a];
				v = TOP_0 + e.a * LANE_H + BODY_H / 2;
				probePixel(h, v, 1'b1, expectColor(h, v));
			end
			OP_RANDPIX:
				repeat (e.a)
				begin
					@(negedge clk);
					h = int'($urandom_range(1023, 0));
					v = int'($urandom_range(1023, 0));
					probePixel(h, v, 1'b1, expectColor(h, v));
				end
			OP_KILLS:
			begin
				// count lags the kill edge
				for (int t = 0; t < 3 && zombiesKilled != killCount_t'(e.val); t++)
					@(negedge clk);
				checkKills(killCount_t'(e.val), zombiesKilled);
			end
			OP_STATE:
			begin
				for (int t = 0; t < 2 && gameState != gameState_e'(e.val); t++)
					@(negedge clk);
				checkState(gameState_e'(e.val), gameState);
			end
			OP_PLANT:
			begin
				@(negedge clk);
				checkPlant(plantType_e'(e.val), plantChoice);
			end
			OP_WINHITS:
				hitAllRandom();
			OP_RESET:
				resetDut();
			OP_LOSS:
			begin
				// lane 1 leads, so it reaches the end first
				while (!modelLost)
					@(negedge clk);
				for (int t = 0; t < 2 && gameState != Lost; t++)
					@(negedge clk);
				checkState(Lost, gameState);
			end
			default:
				stopWithFailure($sformatf("Unknown operation %0d in the stimulus table", e.op));
		endcase
	endtask

	initial
	begin
		void'($urandom(32'h5084_6980));
		rstN = 1'b0;
		bright = 1'b1;
		hCount = '0;
		vCount = '0;
		selectButton = 1'b0;
		leftButton = 1'b0;
		rightButton = 1'b0;
		peaHit = '0;
		buildTable();
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		foreach (opQueue[k])
			applyOp(opQueue[k]);
		$display("TEST RESULT: PASS");
		$finish;
	end

	// hard stop if a wait never ends
	initial
	begin
		#(WATCHDOG_NS);
		stopWithFailure("Watchdog expired: the test sequence did not finish in time");
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+bench
src/lawnPkg.sv
src/hordeIf.sv
src/zombieLane.sv
src/zombieHorde.sv
src/gameControl.sv
src/plantSelector.sv
src/pixelPainter.sv
src/lawnGameTop.sv
bench/lawnGameTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lawn game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module lawnGameTb \
	-f project.f -Mdir obj_dir -o lawnGameSim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/lawnGameSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
